// ==== hw/dataflowPkg.sv ====
package dataflowPkg;

    // Control line positions inside the flag vector
    localparam int NUM_FLAGS = 72;

    // DB, ADL and ADH sources
    localparam int SET_DB_TO_PSR = 0, SET_DB_TO_PCH = 1, SET_DB_TO_PCL = 2,
                   SET_DB_TO_ACC = 3, SET_DB_TO_DATA = 4, SET_DB_HIGH = 5;
    localparam int SET_ADL_TO_SP = 6, SET_ADL_TO_ALU = 7, SET_ADL_TO_PCL = 8,
                   SET_ADL_TO_DATA = 9;
    localparam int SET_ADL_FF = 10, SET_ADL_FE = 11, SET_ADL_FD = 12,
                   SET_ADL_FC = 13, SET_ADL_FB = 14, SET_ADL_FA = 15, SET_ADL_00 = 16;
    localparam int SET_ADH_TO_PCH = 17, SET_ADH_TO_DATA = 18, SET_ADH_FF = 19,
                   SET_ADH_LOW = 20, SET_ADH_TO_ONE = 21;

    // SB sources
    localparam int SET_SB_TO_X = 22, SET_SB_TO_Y = 23, SET_SB_TO_SP = 24,
                   SET_SB_TO_ALU = 25, SET_SB_TO_ACC = 26, SET_SB_HIGH = 27;

    // Pass transistors named by source and destination
    localparam int SET_DB_TO_SB = 28, SET_SB_TO_DB = 29;
    localparam int SET_ADH_TO_SB = 30, SET_SB_TO_ADH = 31;

    // Register loads
    localparam int LOAD_X = 32, LOAD_Y = 33, LOAD_SP = 34, LOAD_ACC = 35;
    localparam int LOAD_ALU = 36, LOAD_DOR = 37, LOAD_ABL = 38, LOAD_ABH = 39;

    localparam int LOAD_PC = 40, PC_INC = 41, PC_DEC = 42;

    // ALU operand, carry-in and operation selects
    localparam int SET_INPUT_A_TO_SB = 43, SET_INPUT_A_TO_LOW = 44;
    localparam int SET_INPUT_B_TO_DB = 45, SET_INPUT_B_TO_NOT_DB = 46,
                   SET_INPUT_B_TO_ADL = 47;
    localparam int SET_ALU_CARRY_HIGH = 48, SET_ALU_CARRY_TO_FREE_CARRY = 49,
                   SET_ALU_CARRY_TO_PSR_CARRY = 50;
    localparam int ALU_ADD = 51, ALU_AND = 52, ALU_XOR = 53, ALU_OR = 54,
                   ALU_R_SHIFT = 55;

    // Status register loads
    localparam int SET_PSR_TO_DB = 56, SET_PSR_C_TO_DB0 = 57, SET_PSR_Z_TO_DB1 = 58,
                   SET_PSR_I_TO_DB2 = 59, SET_PSR_D_TO_DB3 = 60,
                   SET_PSR_V_TO_DB6 = 61, SET_PSR_N_TO_DB7 = 62;
    localparam int PSR_DATA_TO_LOAD = 63, LOAD_CARRY_PSR_FLAG = 64,
                   LOAD_INTERUPT_PSR_FLAG = 65, LOAD_DECIMAL_PSR_FLAG = 66,
                   LOAD_OVERFLOW_PSR_FLAG = 67;
    localparam int SET_PSR_CARRY_TO_ALU_CARRY = 68, SET_PSR_OVERFLOW_TO_ALU_OVERFLOW = 69,
                   WRITE_ZERO_FLAG = 70, SET_PSR_OUTPUT_BRK_HIGH = 71;

    // Precharged bus with nothing pulling it down
    localparam logic [7:0] BUS_IDLE = 8'hFF;

    // Preset constants
    localparam logic [7:0] PRESET_FF = 8'hFF, PRESET_FE = 8'hFE, PRESET_FD = 8'hFD;
    localparam logic [7:0] PRESET_FC = 8'hFC, PRESET_FB = 8'hFB, PRESET_FA = 8'hFA;
    localparam logic [7:0] PRESET_00 = 8'h00, PRESET_01 = 8'h01;

    // Status byte layout with bit 5 unused
    localparam int PSR_C = 0, PSR_Z = 1, PSR_I = 2, PSR_D = 3;
    localparam int PSR_B = 4, PSR_V = 6, PSR_N = 7;

endpackage

// ==== hw/dataflowIf.sv ====
// Settled internal buses
interface busLinesIf;
    logic [7:0] dataBus;
    logic [7:0] stackBus;
    logic [7:0] addressLowBus;
    logic [7:0] addressHighBus;

    modport network(output dataBus, stackBus, addressLowBus, addressHighBus);
    modport user(input dataBus, stackBus, addressLowBus, addressHighBus);
endinterface

// Register values that can be put onto the buses
interface regSourcesIf;
    logic [7:0] xReg;
    logic [7:0] yReg;
    logic [7:0] spReg;
    logic [7:0] accReg;
    logic [7:0] aluHold;
    logic [7:0] pclReg;
    logic [7:0] pchReg;
    logic [7:0] psrByte; // DB read-out form of the PSR

    modport regs(output xReg, yReg, spReg, accReg, aluHold);
    modport pc(output pclReg, pchReg);
    modport psr(output psrByte);
    modport network(
        input xReg, yReg, spReg, accReg, aluHold, pclReg, pchReg, psrByte
    );
endinterface

// ==== hw/busNetwork.sv ====
module busNetwork import dataflowPkg::*; (
    input logic [NUM_FLAGS-1:0] flags,
    input logic [7:0]           externalDBRead,
    regSourcesIf.network        sources,
    busLinesIf.network          buses
);
    logic [7:0] dbLocal;  // Buses before the pass transistors
    logic [7:0] sbLocal;
    logic [7:0] adlLocal;
    logic [7:0] adhLocal;
    logic [7:0] sbSettled;

    // A selected source can only pull bits low
    function automatic logic [7:0] pull(
        input logic [7:0] bus,
        input logic       sel,
        input logic [7:0] value
    );
        return sel ? (bus & value) : bus;
    endfunction

    always_comb begin
        dbLocal = BUS_IDLE;
        dbLocal = pull(dbLocal, flags[SET_DB_TO_PSR], sources.psrByte);
        dbLocal = pull(dbLocal, flags[SET_DB_TO_PCH], sources.pchReg);
        dbLocal = pull(dbLocal, flags[SET_DB_TO_PCL], sources.pclReg);
        dbLocal = pull(dbLocal, flags[SET_DB_TO_ACC], sources.accReg);
        dbLocal = pull(dbLocal, flags[SET_DB_TO_DATA], externalDBRead);
        dbLocal = pull(dbLocal, flags[SET_DB_HIGH], PRESET_FF);
    end

    always_comb begin
        sbLocal = BUS_IDLE;
        sbLocal = pull(sbLocal, flags[SET_SB_TO_X], sources.xReg);
        sbLocal = pull(sbLocal, flags[SET_SB_TO_Y], sources.yReg);
        sbLocal = pull(sbLocal, flags[SET_SB_TO_SP], sources.spReg);
        sbLocal = pull(sbLocal, flags[SET_SB_TO_ALU], sources.aluHold);
        sbLocal = pull(sbLocal, flags[SET_SB_TO_ACC], sources.accReg);
        sbLocal = pull(sbLocal, flags[SET_SB_HIGH], PRESET_FF);
    end

    always_comb begin
        adlLocal = BUS_IDLE;
        adlLocal = pull(adlLocal, flags[SET_ADL_TO_SP], sources.spReg);
        adlLocal = pull(adlLocal, flags[SET_ADL_TO_ALU], sources.aluHold);
        adlLocal = pull(adlLocal, flags[SET_ADL_TO_PCL], sources.pclReg);
        adlLocal = pull(adlLocal, flags[SET_ADL_TO_DATA], externalDBRead);
        adlLocal = pull(adlLocal, flags[SET_ADL_FF], PRESET_FF);
        adlLocal = pull(adlLocal, flags[SET_ADL_FE], PRESET_FE);
        adlLocal = pull(adlLocal, flags[SET_ADL_FD], PRESET_FD);
        adlLocal = pull(adlLocal, flags[SET_ADL_FC], PRESET_FC);
        adlLocal = pull(adlLocal, flags[SET_ADL_FB], PRESET_FB);
        adlLocal = pull(adlLocal, flags[SET_ADL_FA], PRESET_FA);
        adlLocal = pull(adlLocal, flags[SET_ADL_00], PRESET_00);
    end

    always_comb begin
        adhLocal = BUS_IDLE;
        adhLocal = pull(adhLocal, flags[SET_ADH_TO_PCH], sources.pchReg);
        adhLocal = pull(adhLocal, flags[SET_ADH_TO_DATA], externalDBRead);
        adhLocal = pull(adhLocal, flags[SET_ADH_FF], PRESET_FF);
        adhLocal = pull(adhLocal, flags[SET_ADH_LOW], PRESET_00);
        adhLocal = pull(adhLocal, flags[SET_ADH_TO_ONE], PRESET_01);
    end

    // SB sits between DB and ADH, so it collects from both bridges first
    assign sbSettled = sbLocal
                     & (flags[SET_DB_TO_SB] ? dbLocal : BUS_IDLE)
                     & (flags[SET_ADH_TO_SB] ? adhLocal : BUS_IDLE);

    assign buses.stackBus       = sbSettled;
    assign buses.dataBus        = dbLocal & (flags[SET_SB_TO_DB] ? sbSettled : BUS_IDLE);
    assign buses.addressHighBus = adhLocal & (flags[SET_SB_TO_ADH] ? sbSettled : BUS_IDLE);
    assign buses.addressLowBus  = adlLocal; // No bridge on ADL

endmodule

// ==== hw/registerFile.sv ====
module registerFile import dataflowPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [NUM_FLAGS-1:0] flags,
    busLinesIf.user              buses,
    regSourcesIf.regs            sources,
    input  logic [7:0]           aluResult,
    output logic [7:0]           externalDBWrite, // DOR
    output logic [7:0]           addressLow,      // ABL
    output logic [7:0]           addressHigh      // ABH
);
    logic [7:0] xReg;
    logic [7:0] yReg;
    logic [7:0] spReg;
    logic [7:0] accReg;
    logic [7:0] aluHold;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            xReg            <= '0;
            yReg            <= '0;
            spReg           <= '0;
            accReg          <= '0;
            aluHold         <= '0;
            externalDBWrite <= '0;
            addressLow      <= '0;
            addressHigh     <= '0;
        end else begin
            // Index, stack and accumulator all fill from SB
            if (flags[LOAD_X])   xReg   <= buses.stackBus;
            if (flags[LOAD_Y])   yReg   <= buses.stackBus;
            if (flags[LOAD_SP])  spReg  <= buses.stackBus;
            if (flags[LOAD_ACC]) accReg <= buses.stackBus;

            if (flags[LOAD_ALU]) aluHold <= aluResult;

            // Output latches toward the pins
            if (flags[LOAD_DOR]) externalDBWrite <= buses.dataBus;
            if (flags[LOAD_ABL]) addressLow      <= buses.addressLowBus;
            if (flags[LOAD_ABH]) addressHigh     <= buses.addressHighBus;
        end
    end

    assign sources.xReg    = xReg;
    assign sources.yReg    = yReg;
    assign sources.spReg   = spReg;
    assign sources.accReg  = accReg;
    assign sources.aluHold = aluHold;

endmodule

// ==== hw/programCounter.sv ====
module programCounter import dataflowPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [NUM_FLAGS-1:0] flags,
    busLinesIf.user              buses,
    regSourcesIf.pc              sources,
    output logic                 pclMSB
);
    logic [7:0]  pcl;
    logic [7:0]  pch;
    logic [15:0] basePc;
    logic [15:0] nextPc;

    // Jump target from the address buses, otherwise hold the current PC
    assign basePc = flags[LOAD_PC] ? {buses.addressHighBus, buses.addressLowBus}
                                   : {pch, pcl};

    // 16-bit step so the low byte carries or borrows into PCH
    assign nextPc = basePc + 16'(flags[PC_INC]) - 16'(flags[PC_DEC]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcl <= '0;
            pch <= '0;
        end else begin
            pcl <= nextPc[7:0];  // Loads every cycle
            pch <= nextPc[15:8];
        end
    end

    assign sources.pclReg = pcl;
    assign sources.pchReg = pch;
    assign pclMSB         = pcl[7]; // Page-cross hint for control

endmodule

// ==== hw/alu.sv ====
module alu import dataflowPkg::*; (
    input  logic [NUM_FLAGS-1:0] flags,
    input  logic                 freeCarry,
    input  logic                 psrCarry,
    input  logic                 psrDecimal, // Binary ALU without BCD adjust
    busLinesIf.user              buses,
    output logic [7:0]           aluResult,
    output logic                 carryOut,
    output logic                 overflowOut
);
    logic [7:0] operandA;
    logic [7:0] operandB;
    logic       carryIn;
    logic [8:0] sum;

    always_comb begin
        if (flags[SET_INPUT_A_TO_LOW])     operandA = 8'h00;
        else if (flags[SET_INPUT_A_TO_SB]) operandA = buses.stackBus;
        else                               operandA = 8'h00;
    end

    always_comb begin
        if (flags[SET_INPUT_B_TO_DB])          operandB = buses.dataBus;
        else if (flags[SET_INPUT_B_TO_NOT_DB]) operandB = ~buses.dataBus; // Subtract path
        else if (flags[SET_INPUT_B_TO_ADL])    operandB = buses.addressLowBus;
        else                                   operandB = 8'h00;
    end

    assign carryIn = flags[SET_ALU_CARRY_HIGH]
                   | (flags[SET_ALU_CARRY_TO_FREE_CARRY] & freeCarry)
                   | (flags[SET_ALU_CARRY_TO_PSR_CARRY] & psrCarry);

    assign sum = {1'b0, operandA} + {1'b0, operandB} + {8'b0, carryIn};

    always_comb begin
        aluResult   = 8'h00;
        carryOut    = 1'b0;
        overflowOut = 1'b0;
        if (flags[ALU_ADD]) begin
            aluResult = sum[7:0];
            carryOut  = sum[8];
            // Same-sign operands giving a result of the other sign
            overflowOut = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);
        end else if (flags[ALU_AND]) begin
            aluResult = operandA & operandB;
        end else if (flags[ALU_XOR]) begin
            aluResult = operandA ^ operandB;
        end else if (flags[ALU_OR]) begin
            aluResult = operandA | operandB;
        end else if (flags[ALU_R_SHIFT]) begin
            aluResult = {carryIn, operandA[7:1]}; // Rotate through carry
            carryOut  = operandA[0];
        end
    end

endmodule

// ==== hw/statusRegister.sv ====
module statusRegister import dataflowPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [NUM_FLAGS-1:0] flags,
    input  logic                 setOverflow,
    input  logic                 aluCarry,
    input  logic                 aluOverflow,
    busLinesIf.user              buses,
    regSourcesIf.psr             sources,
    output logic [7:0]           psrOut
);
    logic [7:0] psrReg; // Bit 5 never written
    logic       dbAll;
    logic       manualBit;

    assign dbAll     = flags[SET_PSR_TO_DB];
    assign manualBit = flags[PSR_DATA_TO_LOAD];

    // Later assignments win when several sources hit the same flag
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            psrReg <= '0;
        end else begin
            if (dbAll || flags[SET_PSR_C_TO_DB0]) psrReg[PSR_C] <= buses.dataBus[PSR_C];
            if (dbAll || flags[SET_PSR_Z_TO_DB1]) psrReg[PSR_Z] <= buses.dataBus[PSR_Z];
            if (dbAll || flags[SET_PSR_I_TO_DB2]) psrReg[PSR_I] <= buses.dataBus[PSR_I];
            if (dbAll || flags[SET_PSR_D_TO_DB3]) psrReg[PSR_D] <= buses.dataBus[PSR_D];
            if (dbAll || flags[SET_PSR_V_TO_DB6]) psrReg[PSR_V] <= buses.dataBus[PSR_V];
            if (dbAll || flags[SET_PSR_N_TO_DB7]) psrReg[PSR_N] <= buses.dataBus[PSR_N];

            if (flags[LOAD_CARRY_PSR_FLAG])    psrReg[PSR_C] <= manualBit;
            if (flags[LOAD_INTERUPT_PSR_FLAG]) psrReg[PSR_I] <= manualBit;
            if (flags[LOAD_DECIMAL_PSR_FLAG])  psrReg[PSR_D] <= manualBit;
            if (flags[LOAD_OVERFLOW_PSR_FLAG]) psrReg[PSR_V] <= manualBit;

            if (flags[SET_PSR_CARRY_TO_ALU_CARRY])       psrReg[PSR_C] <= aluCarry;
            if (flags[SET_PSR_OVERFLOW_TO_ALU_OVERFLOW]) psrReg[PSR_V] <= aluOverflow;
            if (flags[WRITE_ZERO_FLAG]) psrReg[PSR_Z] <= (buses.dataBus == 8'h00);

            // SO pin
            if (setOverflow) psrReg[PSR_V] <= 1'b1;

            psrReg[PSR_B] <= flags[SET_PSR_OUTPUT_BRK_HIGH]; // Follows the flag every cycle
        end
    end

    assign psrOut = psrReg;

    // Unused bit 5 reads high when pushed onto DB
    assign sources.psrByte = psrReg | 8'b0010_0000;

endmodule

// ==== hw/internalDataflow.sv ====
module internalDataflow import dataflowPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 freeCarry,
    input  logic                 psrCarry,
    input  logic                 setOverflow,
    input  logic [NUM_FLAGS-1:0] flags,
    input  logic [7:0]           externalDBRead,
    output logic [7:0]           externalDBWrite,
    output logic [7:0]           externalAddressBusLowOutput,
    output logic [7:0]           externalAddressBusHighOutput,
    output logic [7:0]           psrRegToLogicController,
    output logic                 aluCarryOut,
    output logic                 pclMSB
);
    busLinesIf   busLines();
    regSourcesIf regSources();

    logic [7:0] aluResult;
    logic       aluOverflow;

    busNetwork busNet (
        .flags(flags),
        .externalDBRead(externalDBRead),
        .sources(regSources),
        .buses(busLines)
    );

    registerFile regFile (
        .clk(clk),
        .rstN(rstN),
        .flags(flags),
        .buses(busLines),
        .sources(regSources),
        .aluResult(aluResult),
        .externalDBWrite(externalDBWrite),
        .addressLow(externalAddressBusLowOutput),
        .addressHigh(externalAddressBusHighOutput)
    );

    programCounter pc (
        .clk(clk),
        .rstN(rstN),
        .flags(flags),
        .buses(busLines),
        .sources(regSources),
        .pclMSB(pclMSB)
    );

    alu aluUnit (
        .flags(flags),
        .freeCarry(freeCarry),
        .psrCarry(psrCarry),
        .psrDecimal(psrRegToLogicController[PSR_D]), // Stored D flag
        .buses(busLines),
        .aluResult(aluResult),
        .carryOut(aluCarryOut),
        .overflowOut(aluOverflow)
    );

    statusRegister psr (
        .clk(clk),
        .rstN(rstN),
        .flags(flags),
        .setOverflow(setOverflow),
        .aluCarry(aluCarryOut),
        .aluOverflow(aluOverflow),
        .buses(busLines),
        .sources(regSources),
        .psrOut(psrRegToLogicController)
    );

endmodule

// ==== verification/dataflow_checker.sv ====
module dataflow_checker import dataflowPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic [NUM_FLAGS-1:0] flags,
    input logic [7:0]           dataBus,
    input logic [15:0]          pcValue,
    input logic                 aluCarryOut
);
    timeunit 1ns;
    timeprecision 1ns;

    int failCount = 0; // Read by the testbench at the end of the run

    // Precharged DB when nothing pulls it down
    dbIdle: assert property (@(posedge clk) disable iff (!rstN)
        (flags[SET_DB_HIGH:SET_DB_TO_PSR] == '0 && !flags[SET_SB_TO_DB])
            |-> dataBus == BUS_IDLE)
        else begin
            failCount++;
            $error("DB is not idle with no source and the SB bridge closed");
        end

    pcStep: assert property (@(posedge clk) disable iff (!rstN)
        (!flags[LOAD_PC] && flags[PC_INC] && !flags[PC_DEC])
            |=> pcValue == $past(pcValue) + 16'd1)
        else begin
            failCount++;
            $error("PC did not advance by one on a plain increment");
        end

    // ADD has priority over the logic operations
    logicCarry: assert property (@(posedge clk) disable iff (!rstN)
        (!flags[ALU_ADD] && (flags[ALU_AND] || flags[ALU_XOR] || flags[ALU_OR]))
            |-> !aluCarryOut)
        else begin
            failCount++;
            $error("ALU carry out is set during a logic operation");
        end

endmodule

bind internalDataflow dataflow_checker chk0 (
    .clk(clk),
    .rstN(rstN),
    .flags(flags),
    .dataBus(busLines.dataBus),
    .pcValue({regSources.pchReg, regSources.pclReg}),
    .aluCarryOut(aluCarryOut)
);

// ==== verification/dataflowTb.sv ====
module dataflowTb import dataflowPkg::*; ;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PERIOD = 100;
    localparam int TEST_CYCLES = 70;   // Reset plus all directed tests
    localparam int MARGIN_CYCLES = 30;
    localparam logic [31:0] SEED = 32'h2f1118f1;

    logic                 clk;
    logic                 rstN;
    logic                 freeCarry;
    logic                 psrCarry;
    logic                 setOverflow;
    logic [NUM_FLAGS-1:0] flags;
    logic [7:0]           externalDBRead;
    logic [7:0]           externalDBWrite;
    logic [7:0]           externalAddressBusLowOutput;
    logic [7:0]           externalAddressBusHighOutput;
    logic [7:0]           psrRegToLogicController;
    logic                 aluCarryOut;
    logic                 pclMSB;

    internalDataflow dut0 (.*);

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("TEST FAIL");
        $fatal(1, "Timeout, tests did not finish in %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    end

    function automatic logic [NUM_FLAGS-1:0] flagSet(int i0, int i1 = -1, int i2 = -1,
                                                     int i3 = -1, int i4 = -1, int i5 = -1);
        logic [NUM_FLAGS-1:0] v;
        int idx[6];
        idx = '{i0, i1, i2, i3, i4, i5};
        v = '0;
        foreach (idx[k]) begin
            if (idx[k] >= 0) v[idx[k]] = 1'b1;
        end
        return v;
    endfunction

    // Flags hold for one whole cycle and results are read at the falling edge
    task automatic runCycle(input logic [NUM_FLAGS-1:0] f, input logic [7:0] data = 8'h00,
                            input logic so = 1'b0);
        @(posedge clk);
        flags          <= f;
        externalDBRead <= data;
        setOverflow    <= so;
        @(negedge clk);
    endtask

    task automatic checkByte(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        checkByte(what, {7'b0, got}, {7'b0, exp});
    endtask

    // Binary ALU reference from the operation definitions
    task automatic aluModel(input int op, input logic [7:0] a, input logic [7:0] b,
                            input logic cin, output logic [7:0] res,
                            output logic carry, output logic ovf);
        int total;
        int signedTotal;
        total = int'(a) + int'(b) + int'(cin);
        signedTotal = int'($signed(a)) + int'($signed(b)) + int'(cin);
        res = 8'h00;
        carry = 1'b0;
        ovf = 1'b0;
        case (op)
            ALU_ADD: begin
                res = total[7:0];
                carry = (total > 255);
                ovf = (signedTotal > 127) || (signedTotal < -128);
            end
            ALU_AND: res = a & b;
            ALU_XOR: res = a ^ b;
            ALU_OR:  res = a | b;
            ALU_R_SHIFT: begin
                res = {cin, a[7:1]};
                carry = a[0];
            end
            default: res = 8'h00;
        endcase
    endtask

    task automatic resetOutputs();
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkByte("DOR after reset", externalDBWrite, 8'h00);
        checkByte("ABL after reset", externalAddressBusLowOutput, 8'h00);
        checkByte("ABH after reset", externalAddressBusHighOutput, 8'h00);
        checkByte("PSR after reset", psrRegToLogicController, 8'h00);
        checkBit("ALU carry after reset", aluCarryOut, 1'b0);
        checkBit("PCL MSB after reset", pclMSB, 1'b0);
    endtask

    task automatic registerRoundTrip();
        logic [7:0] v;
        v = 8'($urandom);
        runCycle(flagSet(SET_DB_TO_DATA, SET_DB_TO_SB, LOAD_X), v); // Pins to X
        runCycle(flagSet(SET_SB_TO_X, SET_SB_TO_DB, LOAD_DOR));     // X back to DOR
        runCycle('0);
        checkByte("DOR after X round trip", externalDBWrite, v);
    endtask

    task automatic aluOperations();
        int opList[6] = '{ALU_ADD, ALU_ADD, ALU_AND, ALU_XOR, ALU_OR, ALU_R_SHIFT};
        logic [NUM_FLAGS-1:0] f;
        logic [7:0] a;
        logic [7:0] b;
        logic       cin;
        logic [7:0] expRes;
        logic       expCarry;
        logic       expOvf;
        for (int k = 0; k < 6; k++) begin
            a = 8'($urandom);
            b = 8'($urandom);
            cin = (k == 0) ? 1'b1 : 1'($urandom);
            aluModel(opList[k], a, b, cin, expRes, expCarry, expOvf);
            runCycle(flagSet(SET_DB_TO_DATA, SET_DB_TO_SB, LOAD_ACC), a);
            f = flagSet(SET_SB_TO_ACC, SET_INPUT_A_TO_SB, SET_INPUT_B_TO_DB,
                        SET_DB_TO_DATA, opList[k], LOAD_ALU)
              | flagSet(SET_PSR_CARRY_TO_ALU_CARRY, SET_PSR_OVERFLOW_TO_ALU_OVERFLOW);
            f[SET_ALU_CARRY_HIGH] = cin;
            runCycle(f, b);
            checkBit("ALU carry out", aluCarryOut, expCarry);
            runCycle(flagSet(SET_ADL_TO_ALU, LOAD_ABL)); // Hold register onto ADL
            runCycle('0);
            checkByte("ALU result on ABL", externalAddressBusLowOutput, expRes);
            checkBit("PSR carry from ALU", psrRegToLogicController[PSR_C], expCarry);
            checkBit("PSR overflow from ALU", psrRegToLogicController[PSR_V], expOvf);
        end
    endtask

    task automatic pcIncrement();
        logic [15:0] pcExp;
        runCycle(flagSet(SET_ADH_TO_ONE, SET_ADL_FC, LOAD_PC));
        for (int step = 1; step <= 6; step++) begin
            pcExp = 16'h01FC + 16'(step); // Crosses into page 02
            runCycle(flagSet(PC_INC));
            runCycle(flagSet(SET_ADL_TO_PCL, SET_ADH_TO_PCH, LOAD_ABL, LOAD_ABH));
            runCycle('0);
            checkByte("PCL on ABL", externalAddressBusLowOutput, pcExp[7:0]);
            checkByte("PCH on ABH", externalAddressBusHighOutput, pcExp[15:8]);
            checkBit("PCL MSB", pclMSB, pcExp[7]);
        end
    endtask

    task automatic busPulldown();
        logic [7:0] v;
        v = 8'($urandom);
        runCycle(flagSet(LOAD_ABL)); // Nothing on ADL
        runCycle('0);
        checkByte("idle ADL on ABL", externalAddressBusLowOutput, 8'hFF);
        runCycle(flagSet(SET_ADL_TO_DATA, SET_ADL_FB, LOAD_ABL), v);
        runCycle('0);
        checkByte("two ADL sources on ABL", externalAddressBusLowOutput, v & 8'hFB);
    endtask

    task automatic statusFlags();
        logic [7:0] v;
        logic [7:0] expPsr;
        v = 8'($urandom);
        runCycle(flagSet(SET_DB_TO_DATA, SET_PSR_TO_DB), v);
        runCycle('0);
        checkByte("PSR loaded from DB", psrRegToLogicController, v & 8'hCF); // B and bit 5 stay clear

        runCycle(flagSet(SET_DB_TO_DATA, SET_PSR_TO_DB), 8'h00);
        runCycle(flagSet(SET_DB_TO_DATA, SET_DB_TO_SB, LOAD_ACC), 8'hF0);
        runCycle(flagSet(SET_SB_TO_ACC, SET_INPUT_A_TO_SB, SET_INPUT_B_TO_DB,
                         SET_DB_TO_DATA, ALU_ADD, SET_PSR_CARRY_TO_ALU_CARRY), 8'h20);
        runCycle('0);
        expPsr = 8'h00;
        expPsr[PSR_C] = 1'b1; // F0 + 20 carries out
        checkByte("PSR carry after add", psrRegToLogicController, expPsr);

        runCycle(flagSet(SET_DB_TO_DATA, WRITE_ZERO_FLAG), 8'h00);
        runCycle('0);
        expPsr[PSR_Z] = 1'b1;
        checkByte("PSR zero from DB", psrRegToLogicController, expPsr);

        runCycle('0, 8'h00, 1'b1);
        runCycle('0);
        expPsr[PSR_V] = 1'b1;
        checkByte("PSR overflow from SO", psrRegToLogicController, expPsr);

        runCycle(flagSet(SET_PSR_OUTPUT_BRK_HIGH));
        runCycle('0);
        checkByte("PSR with B set", psrRegToLogicController, expPsr | 8'h10);
        runCycle('0);
        checkByte("PSR with B cleared", psrRegToLogicController, expPsr);
    endtask

    initial begin
        clk            = 1'b0;
        rstN           = 1'b0;
        freeCarry      = 1'b0;
        psrCarry       = 1'b0;
        setOverflow    = 1'b0;
        flags          = '0;
        externalDBRead = 8'h00;
        void'($urandom(SEED));

        resetOutputs();
        registerRoundTrip();
        aluOperations();
        pcIncrement();
        busPulldown();
        statusFlags();
        runCycle('0); // Last edge for the bound assertions

        if (dut0.chk0.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/dataflowPkg.sv
hw/dataflowIf.sv
hw/busNetwork.sv
hw/registerFile.sv
hw/programCounter.sv
hw/alu.sv
hw/statusRegister.sv
hw/internalDataflow.sv
verification/dataflow_checker.sv
verification/dataflowTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module dataflowTb \
    --Mdir obj_dir -o simv -f src.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/simv +verilator+error+limit+100 > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ "$simStatus" -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
